/* include/mac_table_cfg.svh */
`ifndef MAC_TABLE_CFG_SVH
`define MAC_TABLE_CFG_SVH

// Table geometry
// Rows in each way, power of two, no more than 64K rows
`define MAC_TABLE_ROWS 16

// Associative ways, power of two
`define MAC_TABLE_WAYS 4

// Learned addresses that can wait for a free table cycle
`define MAC_PENDING_SIZE 4

// Read latency of the table memory, address to data
`define MAC_RAM_LATENCY 2

`endif

/* hw/mac_types_pkg.sv */
`default_nettype none

`include "mac_table_cfg.svh"

package mac_types_pkg;

	// Fields taken from an Ethernet frame
	typedef logic [47:0] macaddr_t;
	typedef logic [11:0] vlan_t;

	// Switch port, 0 to 31
	typedef logic [4:0] port_t;

	// Index into one way of the table
	typedef logic [$clog2(`MAC_TABLE_ROWS)-1:0] row_t;

	// Way select within a row
	typedef logic [$clog2(`MAC_TABLE_WAYS)-1:0] way_t;

	// One stored address, 66 bits
	// Valid sits on top so an all-zero word is an empty entry
	typedef struct packed {
		logic     valid;
		vlan_t    vlan;
		port_t    port;
		macaddr_t mac;
	} entry_t;

endpackage

`default_nettype wire

/* hw/table_ops_pkg.sv */
`default_nettype none

package table_ops_pkg;

	import mac_types_pkg::*;

	// What the second memory port does in a given cycle
	typedef enum logic [1:0] {
		RAM_OP_IDLE,
		RAM_OP_SRC_READ,
		RAM_OP_LEARN_WRITE
	} ram_op_t;

	// Row select for an address
	// Fold the MAC into 16 bits, mix in the VLAN, keep the low row bits
	function automatic row_t row_hash(
		input macaddr_t mac,
		input vlan_t    vlan
	);
		logic [15:0] fold;

		fold = mac[47:32] ^ mac[31:16] ^ mac[15:0] ^ {4'h0, vlan};
		return fold[$bits(row_t)-1:0];
	endfunction

endpackage

`default_nettype wire

/* hw/lookup_pipe.sv */
`default_nettype none
`timescale 1ns/1ps

`include "mac_table_cfg.svh"

module lookup_pipe
	import mac_types_pkg::*;
	import table_ops_pkg::*;
(
	input  wire           clk,
	input  wire           rst_n,
	input  wire           lookup_en,
	input  wire macaddr_t lookup_src_mac,
	input  wire vlan_t    lookup_src_vlan,
	input  wire port_t    lookup_src_port,
	input  wire macaddr_t lookup_dst_mac,
	output row_t          src_row,
	output row_t          dst_row,
	output logic          key_valid,
	output macaddr_t      key_src_mac,
	output vlan_t         key_vlan,
	output port_t         key_src_port,
	output macaddr_t      key_dst_mac
);

	localparam int LAT = `MAC_RAM_LATENCY;

	// Row indexes go straight to the memory address registers
	// Source and destination share one VLAN
	assign src_row = row_hash(lookup_src_mac, lookup_src_vlan);
	assign dst_row = row_hash(lookup_dst_mac, lookup_src_vlan);

	////////////////////////////////////////////////////////////////////////////
	// Key delay line, one stage per memory read cycle

	logic [LAT-1:0] vld_sr;
	macaddr_t       src_mac_sr [LAT];
	vlan_t          vlan_sr    [LAT];
	port_t          port_sr    [LAT];
	macaddr_t       dst_mac_sr [LAT];

	// Strobe
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			vld_sr <= '0;
		end else begin
			vld_sr[0] <= lookup_en;
			for (int i = 1; i < LAT; i++) begin
				vld_sr[i] <= vld_sr[i-1];
			end
		end
	end

	// Key fields, qualified by the strobe downstream
	always_ff @(posedge clk) begin
		src_mac_sr[0] <= lookup_src_mac;
		vlan_sr[0]    <= lookup_src_vlan;
		port_sr[0]    <= lookup_src_port;
		dst_mac_sr[0] <= lookup_dst_mac;
		for (int i = 1; i < LAT; i++) begin
			src_mac_sr[i] <= src_mac_sr[i-1];
			vlan_sr[i]    <= vlan_sr[i-1];
			port_sr[i]    <= port_sr[i-1];
			dst_mac_sr[i] <= dst_mac_sr[i-1];
		end
	end

	// Last stage lines up with the read data
	assign key_valid    = vld_sr[LAT-1];
	assign key_src_mac  = src_mac_sr[LAT-1];
	assign key_vlan     = vlan_sr[LAT-1];
	assign key_src_port = port_sr[LAT-1];
	assign key_dst_mac  = dst_mac_sr[LAT-1];

endmodule

`default_nettype wire

/* hw/mac_table_ram.sv */
`default_nettype none
`timescale 1ns/1ps

`include "mac_table_cfg.svh"

module mac_table_ram
	import mac_types_pkg::*;
	import table_ops_pkg::*;
(
	input  wire         clk,
	input  wire         lookup_en,
	input  wire row_t   dst_row,
	input  wire row_t   src_row,
	input  wire         wr_req,
	input  wire row_t   wr_row,
	input  wire way_t   wr_way,
	input  wire entry_t wr_entry,
	output logic        wr_accept,
	output entry_t      dst_rdata [`MAC_TABLE_WAYS],
	output entry_t      src_rdata [`MAC_TABLE_WAYS]
);

	////////////////////////////////////////////////////////////////////////////
	// Port B arbitration

	ram_op_t op;

	// Source reads come first, they keep the lookup rate at one per clock
	// Learn writes only get idle cycles
	always_comb begin
		if (lookup_en) begin
			op = RAM_OP_SRC_READ;
		end else if (wr_req) begin
			op = RAM_OP_LEARN_WRITE;
		end else begin
			op = RAM_OP_IDLE;
		end
	end

	// Write happens in this same cycle
	assign wr_accept = (op == RAM_OP_LEARN_WRITE);

	////////////////////////////////////////////////////////////////////////////
	// One dual-port array per way

	for (genvar w = 0; w < `MAC_TABLE_WAYS; w++) begin : g_way
		// Table comes up empty at configuration
		entry_t mem [`MAC_TABLE_ROWS] = '{default: '0};

		// Read register then output register on each port
		entry_t dst_q1;
		entry_t dst_q2;
		entry_t src_q1;
		entry_t src_q2;

		// Port A, destination lookup only
		always_ff @(posedge clk) begin
			if (lookup_en) begin
				dst_q1 <= mem[dst_row];
			end
			dst_q2 <= dst_q1;
		end

		// Port B, source lookup or learn write into the chosen way
		always_ff @(posedge clk) begin
			case (op)
				RAM_OP_SRC_READ: src_q1 <= mem[src_row];
				RAM_OP_LEARN_WRITE: begin
					if (wr_way == way_t'(w)) begin
						mem[wr_row] <= wr_entry;
					end
				end
				default: ;
			endcase
			src_q2 <= src_q1;
		end

		assign dst_rdata[w] = dst_q2;
		assign src_rdata[w] = src_q2;
	end

endmodule

`default_nettype wire

/* hw/match_stage.sv */
`default_nettype none
`timescale 1ns/1ps

`include "mac_table_cfg.svh"

module match_stage
	import mac_types_pkg::*;
(
	input  wire           clk,
	input  wire           rst_n,
	input  wire           key_valid,
	input  wire macaddr_t key_src_mac,
	input  wire vlan_t    key_vlan,
	input  wire port_t    key_src_port,
	input  wire macaddr_t key_dst_mac,
	input  wire entry_t   dst_rdata [`MAC_TABLE_WAYS],
	input  wire entry_t   src_rdata [`MAC_TABLE_WAYS],
	output logic          lookup_hit,
	output port_t         lookup_dst_port,
	output logic          learn_req,
	output macaddr_t      learn_mac,
	output vlan_t         learn_vlan,
	output port_t         learn_port
);

	// Entry holds this address in this VLAN
	function automatic logic entry_match(
		input entry_t   e,
		input vlan_t    vlan,
		input macaddr_t mac
	);
		return e.valid && (e.vlan == vlan) && (e.mac == mac);
	endfunction

	logic  dst_hit_c;
	port_t dst_port_c;
	logic  src_hit_c;

	// Scan all ways on both ports
	// Later ways overwrite earlier ones, so the highest way wins
	always_comb begin
		dst_hit_c  = 1'b0;
		dst_port_c = '0;
		src_hit_c  = 1'b0;
		for (int w = 0; w < `MAC_TABLE_WAYS; w++) begin
			if (entry_match(dst_rdata[w], key_vlan, key_dst_mac)) begin
				dst_hit_c  = 1'b1;
				dst_port_c = dst_rdata[w].port;
			end
			if (entry_match(src_rdata[w], key_vlan, key_src_mac)) begin
				src_hit_c = 1'b1;
			end
		end
	end

	// Strobes
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			lookup_hit <= 1'b0;
			learn_req  <= 1'b0;
		end else begin
			lookup_hit <= key_valid && dst_hit_c;
			// Unknown source goes to the learn queue
			learn_req  <= key_valid && !src_hit_c;
		end
	end

	// Payload, only meaningful next to its strobe
	always_ff @(posedge clk) begin
		lookup_dst_port <= dst_port_c;
		learn_mac       <= key_src_mac;
		learn_vlan      <= key_vlan;
		learn_port      <= key_src_port;
	end

endmodule

`default_nettype wire

/* hw/learn_queue.sv */
`default_nettype none
`timescale 1ns/1ps

`include "mac_table_cfg.svh"

module learn_queue
	import mac_types_pkg::*;
	import table_ops_pkg::*;
(
	input  wire           clk,
	input  wire           rst_n,
	input  wire           learn_req,
	input  wire macaddr_t learn_mac,
	input  wire vlan_t    learn_vlan,
	input  wire port_t    learn_port,
	input  wire           wr_accept,
	output logic          wr_req,
	output row_t          wr_row,
	output way_t          wr_way,
	output entry_t        wr_entry
);

	localparam int SLOTS = `MAC_PENDING_SIZE;
	localparam int IDX_W = (SLOTS > 1) ? $clog2(SLOTS) : 1;
	// Source reads still in flight when a write lands
	localparam int HIST  = `MAC_RAM_LATENCY;

	// Pending slots
	logic [SLOTS-1:0] slot_vld;
	entry_t           slot_ent [SLOTS];
	way_t             slot_way [SLOTS];

	// Recently written entries
	logic [HIST-1:0] hist_vld;
	entry_t          hist_ent [HIST];

	// Sequential replacement
	way_t way_ctr;

	entry_t           req_ent;
	logic             dup_c;
	logic             free_found_c;
	logic [IDX_W-1:0] free_idx_c;
	logic [IDX_W-1:0] head_idx_c;
	logic             insert;

	assign req_ent = '{valid: 1'b1, vlan: learn_vlan, port: learn_port, mac: learn_mac};

	function automatic logic same_key(input entry_t a, input entry_t b);
		return (a.mac == b.mac) && (a.vlan == b.vlan) && (a.port == b.port);
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Slot search

	always_comb begin
		dup_c        = 1'b0;
		free_found_c = 1'b0;
		free_idx_c   = '0;
		wr_req       = 1'b0;
		head_idx_c   = '0;
		for (int i = 0; i < SLOTS; i++) begin
			// Already waiting
			if (slot_vld[i] && same_key(slot_ent[i], req_ent)) begin
				dup_c = 1'b1;
			end
			// Lowest free slot takes a new address
			if (!slot_vld[i] && !free_found_c) begin
				free_found_c = 1'b1;
				free_idx_c   = IDX_W'(i);
			end
			// Lowest valid slot goes to the table
			if (slot_vld[i] && !wr_req) begin
				wr_req     = 1'b1;
				head_idx_c = IDX_W'(i);
			end
		end
		// Misses whose source read came before the write are stale repeats
		for (int h = 0; h < HIST; h++) begin
			if (hist_vld[h] && same_key(hist_ent[h], req_ent)) begin
				dup_c = 1'b1;
			end
		end
	end

	// Full queue drops the address
	assign insert = learn_req && !dup_c && free_found_c;

	// Write request from the head slot, held until accepted
	assign wr_row   = row_hash(slot_ent[head_idx_c].mac, slot_ent[head_idx_c].vlan);
	assign wr_way   = slot_way[head_idx_c];
	assign wr_entry = slot_ent[head_idx_c];

	////////////////////////////////////////////////////////////////////////////
	// Queue state

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			slot_vld <= '0;
			hist_vld <= '0;
			way_ctr  <= '0;
		end else begin
			if (wr_accept) begin
				slot_vld[head_idx_c] <= 1'b0;
			end
			// Way advances only for a queued address
			if (insert) begin
				slot_vld[free_idx_c] <= 1'b1;
				way_ctr              <= way_ctr + 1'b1;
			end
			hist_vld[0] <= wr_accept;
			for (int h = 1; h < HIST; h++) begin
				hist_vld[h] <= hist_vld[h-1];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (insert) begin
			slot_ent[free_idx_c] <= req_ent;
			slot_way[free_idx_c] <= way_ctr;
		end
		if (wr_accept) begin
			hist_ent[0] <= slot_ent[head_idx_c];
		end
		for (int h = 1; h < HIST; h++) begin
			hist_ent[h] <= hist_ent[h-1];
		end
	end

endmodule

`default_nettype wire

/* hw/mac_table.sv */
`default_nettype none
`timescale 1ns/1ps

`include "mac_table_cfg.svh"

module mac_table
	import mac_types_pkg::*;
(
	input  wire           clk,
	input  wire           rst_n,
	input  wire           lookup_en,
	input  wire macaddr_t lookup_src_mac,
	input  wire vlan_t    lookup_src_vlan,
	input  wire port_t    lookup_src_port,
	input  wire macaddr_t lookup_dst_mac,
	output logic          lookup_hit,
	output port_t         lookup_dst_port
);

	// Hash stage to memory
	row_t src_row;
	row_t dst_row;

	// Delayed key, aligned with read data
	logic     key_valid;
	macaddr_t key_src_mac;
	vlan_t    key_vlan;
	port_t    key_src_port;
	macaddr_t key_dst_mac;
	entry_t   dst_rdata [`MAC_TABLE_WAYS];
	entry_t   src_rdata [`MAC_TABLE_WAYS];

	// Learning path
	logic     learn_req;
	macaddr_t learn_mac;
	vlan_t    learn_vlan;
	port_t    learn_port;
	logic     wr_req;
	logic     wr_accept;
	row_t     wr_row;
	way_t     wr_way;
	entry_t   wr_entry;

	lookup_pipe u_lookup_pipe (
		.clk(clk), .rst_n(rst_n), .lookup_en(lookup_en),
		.lookup_src_mac(lookup_src_mac), .lookup_src_vlan(lookup_src_vlan),
		.lookup_src_port(lookup_src_port), .lookup_dst_mac(lookup_dst_mac),
		.src_row(src_row), .dst_row(dst_row), .key_valid(key_valid),
		.key_src_mac(key_src_mac), .key_vlan(key_vlan),
		.key_src_port(key_src_port), .key_dst_mac(key_dst_mac)
	);

	mac_table_ram u_ram (
		.clk(clk), .lookup_en(lookup_en), .dst_row(dst_row), .src_row(src_row),
		.wr_req(wr_req), .wr_row(wr_row), .wr_way(wr_way), .wr_entry(wr_entry),
		.wr_accept(wr_accept), .dst_rdata(dst_rdata), .src_rdata(src_rdata)
	);

	match_stage u_match (
		.clk(clk), .rst_n(rst_n), .key_valid(key_valid),
		.key_src_mac(key_src_mac), .key_vlan(key_vlan),
		.key_src_port(key_src_port), .key_dst_mac(key_dst_mac),
		.dst_rdata(dst_rdata), .src_rdata(src_rdata),
		.lookup_hit(lookup_hit), .lookup_dst_port(lookup_dst_port),
		.learn_req(learn_req), .learn_mac(learn_mac),
		.learn_vlan(learn_vlan), .learn_port(learn_port)
	);

	learn_queue u_learn (
		.clk(clk), .rst_n(rst_n), .learn_req(learn_req),
		.learn_mac(learn_mac), .learn_vlan(learn_vlan), .learn_port(learn_port),
		.wr_accept(wr_accept), .wr_req(wr_req), .wr_row(wr_row),
		.wr_way(wr_way), .wr_entry(wr_entry)
	);

endmodule

`default_nettype wire

/* testbench/tb_mac_table.sv */
`default_nettype none
`timescale 1ns/1ps

`include "mac_table_cfg.svh"

module tb_mac_table
	import mac_types_pkg::*;
	import table_ops_pkg::*;
();

	localparam int ROWS      = `MAC_TABLE_ROWS;
	localparam int WAYS      = `MAC_TABLE_WAYS;
	localparam int PEND      = `MAC_PENDING_SIZE;
	// RAM latency plus the compare register, counted from the drive cycle
	localparam int CHK_DEPTH = `MAC_RAM_LATENCY + 1;
	localparam int GAP       = 12;
	localparam int SETTLE    = 20;
	localparam int POOL_N    = 12;
	localparam int N_SPACED  = 40;
	localparam int N_BURST   = 16;
	localparam int TOTAL_CYCLES = 10 + N_SPACED * GAP + N_BURST + SETTLE
		+ PEND + SETTLE + PEND * GAP + 3 + SETTLE + (PEND + 3) * GAP
		+ 4 * GAP + SETTLE;
	localparam logic [31:0] SEED = 32'h1d9b_23d3;
	localparam vlan_t VLAN_A = 12'h00a;
	// Low bits equal to VLAN_A, so one MAC hashes to the same row on both
	localparam vlan_t VLAN_B = 12'h0ba;

	logic     clk;
	logic     rst_n;
	logic     lookup_en;
	macaddr_t lookup_src_mac;
	vlan_t    lookup_src_vlan;
	port_t    lookup_src_port;
	macaddr_t lookup_dst_mac;
	logic     lookup_hit;
	port_t    lookup_dst_port;

	// Reference table and replacement counter
	entry_t model_mem [ROWS][WAYS];
	way_t   model_ctr;
	entry_t learn_list [$];

	// Address pool, even entries on VLAN_A, odd on VLAN_B
	entry_t pool [POOL_N];
	entry_t fresh [PEND];

	// Expected results in packet order, then a delay line to the sample point
	logic             exp_hit_q [$];
	port_t            exp_port_q [$];
	logic [CHK_DEPTH-1:0] pipe_vld;
	logic             pipe_hit [CHK_DEPTH];
	port_t            pipe_port [CHK_DEPTH];
	logic             checking;

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	mac_table UUT (
		.clk(clk), .rst_n(rst_n), .lookup_en(lookup_en),
		.lookup_src_mac(lookup_src_mac), .lookup_src_vlan(lookup_src_vlan),
		.lookup_src_port(lookup_src_port), .lookup_dst_mac(lookup_dst_mac),
		.lookup_hit(lookup_hit), .lookup_dst_port(lookup_dst_port)
	);

	////////////////////////////////////////////////////////////////////////////
	// Reference model

	// Highest valid way with the same VLAN and MAC
	function automatic void model_lookup(input macaddr_t mac, input vlan_t vlan,
		output logic hit, output port_t port);
		row_t r;

		r = row_hash(mac, vlan);
		hit = 1'b0;
		port = '0;
		for (int w = 0; w < WAYS; w++) begin
			if (model_mem[r][w].valid && model_mem[r][w].vlan == vlan &&
				model_mem[r][w].mac == mac) begin
				hit = 1'b1;
				port = model_mem[r][w].port;
			end
		end
	endfunction

	// Pending addresses go in packet order, one way each
	function automatic void apply_learns();
		foreach (learn_list[i]) begin
			model_mem[row_hash(learn_list[i].mac, learn_list[i].vlan)][model_ctr] = learn_list[i];
			model_ctr = model_ctr + 1'b1;
		end
		learn_list.delete();
	endfunction

	// Random address steered into a chosen row
	function automatic entry_t make_entry(input vlan_t vlan, input row_t row);
		entry_t e;
		row_t   r;

		e.valid = 1'b1;
		e.vlan  = vlan;
		e.port  = port_t'($urandom);
		e.mac   = {16'($urandom), 32'($urandom)};
		r = row_hash(e.mac, vlan);
		e.mac[$bits(row_t)-1:0] = e.mac[$bits(row_t)-1:0] ^ r ^ row;
		return e;
	endfunction

	function automatic entry_t anchor_for(input vlan_t vlan);
		return (vlan == VLAN_A) ? pool[0] : pool[1];
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Compare and stop

	task automatic abort_run();
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic check_hit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[FAIL] %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
			abort_run();
		end
	endtask

	task automatic check_port(input string name, input port_t got, input port_t exp);
		if (got !== exp) begin
			$display("[FAIL] %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
			abort_run();
		end
	endtask

	// Outputs sampled mid-cycle; idle cycles must show no hit
	always @(negedge clk) begin
		if (checking) begin
			if (pipe_vld[CHK_DEPTH-1]) begin
				check_hit("lookup_hit", lookup_hit, pipe_hit[CHK_DEPTH-1]);
				if (pipe_hit[CHK_DEPTH-1]) begin
					check_port("lookup_dst_port", lookup_dst_port, pipe_port[CHK_DEPTH-1]);
				end
			end else begin
				check_hit("lookup_hit", lookup_hit, 1'b0);
			end
			for (int i = CHK_DEPTH - 1; i > 0; i--) begin
				pipe_vld[i]  = pipe_vld[i-1];
				pipe_hit[i]  = pipe_hit[i-1];
				pipe_port[i] = pipe_port[i-1];
			end
			pipe_vld[0] = lookup_en;
			if (lookup_en) begin
				if (exp_hit_q.size() == 0) begin
					$display("A lookup was issued with no expected result queued");
					abort_run();
				end
				pipe_hit[0]  = exp_hit_q.pop_front();
				pipe_port[0] = exp_port_q.pop_front();
			end
		end
	end

	initial begin
		repeat (TOTAL_CYCLES * 2 + 1000) @(posedge clk);
		$display("Watchdog timeout, the run did not end within %0d cycles",
			TOTAL_CYCLES * 2 + 1000);
		abort_run();
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus

	task automatic run_idle(input int n);
		repeat (n) begin
			@(posedge clk);
			lookup_en <= 1'b0;
		end
	endtask

	// Expected answer from the table as it stands before this packet
	task automatic send_packet(input entry_t src, input macaddr_t dst);
		logic  hit;
		port_t port;
		logic  dup;

		model_lookup(dst, src.vlan, hit, port);
		exp_hit_q.push_back(hit);
		exp_port_q.push_back(port);
		model_lookup(src.mac, src.vlan, hit, port);
		if (!hit) begin
			dup = 1'b0;
			foreach (learn_list[i]) begin
				if (learn_list[i] == src) dup = 1'b1;
			end
			if (!dup) learn_list.push_back(src);
		end
		@(posedge clk);
		lookup_en       <= 1'b1;
		lookup_src_mac  <= src.mac;
		lookup_src_vlan <= src.vlan;
		lookup_src_port <= src.port;
		lookup_dst_mac  <= dst;
	endtask

	// One packet, then enough idle time for its learn to land
	task automatic send_spaced(input entry_t src, input macaddr_t dst);
		send_packet(src, dst);
		apply_learns();
		run_idle(GAP - 1);
	endtask

	initial begin
		entry_t   src;
		entry_t   a;
		entry_t   b;
		macaddr_t dst;
		row_t     hot_row;
		logic     hit;
		port_t    port;
		int       present [$];

		void'($urandom(SEED));
		rst_n           = 1'b0;
		lookup_en       = 1'b0;
		lookup_src_mac  = '0;
		lookup_src_vlan = '0;
		lookup_src_port = '0;
		lookup_dst_mac  = '0;
		checking        = 1'b0;
		pipe_vld        = '0;
		model_ctr       = '0;
		for (int r = 0; r < ROWS; r++) begin
			for (int w = 0; w < WAYS; w++) begin
				model_mem[r][w] = '0;
			end
		end
		for (int i = 0; i < POOL_N; i++) begin
			pool[i] = make_entry((i % 2) ? VLAN_B : VLAN_A, row_t'($urandom));
		end
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		checking = 1'b1;

		// Spaced packets, some destinations outside the pool
		repeat (N_SPACED) begin
			src = pool[$urandom_range(POOL_N - 1)];
			a = pool[$urandom_range(POOL_N - 1)];
			dst = ($urandom_range(4) == 0) ? {16'($urandom), 32'($urandom)} : a.mac;
			send_spaced(src, dst);
		end

		// Back-to-back burst from learned sources only
		for (int i = 0; i < POOL_N; i++) begin
			model_lookup(pool[i].mac, pool[i].vlan, hit, port);
			if (hit) present.push_back(i);
		end
		if (present.size() == 0) begin
			$display("No learned source was available for the burst");
			abort_run();
		end
		for (int n = 0; n < N_BURST; n++) begin
			src = pool[present[$urandom_range(present.size() - 1)]];
			a = pool[$urandom_range(POOL_N - 1)];
			send_packet(src, a.mac);
		end
		apply_learns();
		run_idle(SETTLE);

		// Burst of new sources, all in one row, then look each one up
		hot_row = row_t'($urandom);
		for (int i = 0; i < PEND; i++) begin
			fresh[i] = make_entry((i % 2) ? VLAN_B : VLAN_A, hot_row);
		end
		for (int i = 0; i < PEND; i++) begin
			a = pool[$urandom_range(POOL_N - 1)];
			send_packet(fresh[i], a.mac);
		end
		apply_learns();
		run_idle(SETTLE);
		for (int i = 0; i < PEND; i++) begin
			send_spaced(anchor_for(fresh[i].vlan), fresh[i].mac);
		end

		// Same new source three times, one learn
		a = make_entry(VLAN_A, hot_row);
		repeat (3) send_packet(a, pool[0].mac);
		apply_learns();
		run_idle(SETTLE);
		// Next new source takes the following way in the same row
		b = make_entry(VLAN_B, hot_row);
		send_spaced(b, pool[1].mac);
		for (int i = 0; i < PEND; i++) begin
			send_spaced(anchor_for(fresh[i].vlan), fresh[i].mac);
		end
		send_spaced(anchor_for(VLAN_A), a.mac);
		send_spaced(anchor_for(VLAN_B), b.mac);

		// Learned MACs seen from the other VLAN, then from their own
		send_spaced(anchor_for(VLAN_A), b.mac);
		send_spaced(anchor_for(VLAN_B), a.mac);
		send_spaced(anchor_for(VLAN_B), b.mac);
		send_spaced(anchor_for(VLAN_A), a.mac);

		run_idle(SETTLE);
		if (exp_hit_q.size() != 0 || pipe_vld != '0) begin
			$display("Lookup results were still outstanding at the end of the run");
			abort_run();
		end else begin
			$display("All tests passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* all.f */
+incdir+include
hw/mac_types_pkg.sv
hw/table_ops_pkg.sv
hw/lookup_pipe.sv
hw/mac_table_ram.sv
hw/match_stage.sv
hw/learn_queue.sv
hw/mac_table.sv
testbench/tb_mac_table.sv
